// File: project.f
+incdir+verilog
verilog/layer_ctrl_pkg.sv
verilog/access_timer.sv
verilog/ahb_access_fsm.sv
verilog/tx_queue.sv
verilog/rx_fifo.sv
verilog/link_handshake.sv
verilog/layer_ctrl_top.sv
bench/node_model.sv
bench/layer_ctrl_tb.sv

// File: Bender.yml
package:
  name: layer_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/layer_ctrl_pkg.sv
      - verilog/access_timer.sv
      - verilog/ahb_access_fsm.sv
      - verilog/tx_queue.sv
      - verilog/rx_fifo.sv
      - verilog/link_handshake.sv
      - verilog/layer_ctrl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/node_model.sv
      - bench/layer_ctrl_tb.sv

// File: bench/layer_ctrl_tb.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module layer_ctrl_tb
	import layer_ctrl_pkg::*;
();

	localparam int CYCLE_LIMIT = 20000;
	localparam int TX_SLOTS = `LC_FIFO_DEPTH - 1;

	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic        HWRITE;
	logic        HREADY;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic [31:0] HADDR;
	msg_data_t   HWDATA;
	logic        HREADYOUT;
	logic [1:0]  HRESP;
	msg_data_t   HRDATA;
	node_addr_t  tx_addr;
	msg_data_t   tx_data;
	logic        tx_req;
	logic        tx_pend;
	logic        tx_ack;
	logic        tx_succ;
	logic        tx_fail;
	logic        tx_resp_ack;
	msg_data_t   rx_data;
	logic        rx_req;
	logic        rx_pend;
	logic        rx_ack;
	logic        rx_frame_complete;
	logic        rx_fifo_empty;
	logic        ack_hold;
	logic [1:0]  ack_delay;

	// reference model
	node_addr_t  exp_addr [$];
	msg_data_t   exp_data [$];
	msg_data_t   exp_rx [$];
	msg_data_t   last_popped;
	logic [31:0] rng;
	int          cycle_count;
	int          fail_count;
	int          delivered;
	int          frame_count;
	int          frames_expected;
	logic        skip_pop;
	logic        tx_req_prev;
	logic        frame_prev;
	logic        pend_exp;

	layer_ctrl_top u_layer_ctrl_top (
		.HCLK              (HCLK),
		.HRESETn           (HRESETn),
		.HSEL              (HSEL),
		.HWRITE            (HWRITE),
		.HREADY            (HREADY),
		.HTRANS            (HTRANS),
		.HSIZE             (HSIZE),
		.HADDR             (HADDR),
		.HWDATA            (HWDATA),
		.HREADYOUT         (HREADYOUT),
		.HRESP             (HRESP),
		.HRDATA            (HRDATA),
		.tx_addr           (tx_addr),
		.tx_data           (tx_data),
		.tx_req            (tx_req),
		.tx_pend           (tx_pend),
		.tx_ack            (tx_ack),
		.tx_succ           (tx_succ),
		.tx_fail           (tx_fail),
		.tx_resp_ack       (tx_resp_ack),
		.rx_data           (rx_data),
		.rx_req            (rx_req),
		.rx_pend           (rx_pend),
		.rx_ack            (rx_ack),
		.rx_frame_complete (rx_frame_complete),
		.rx_fifo_empty     (rx_fifo_empty)
	);

	node_model u_node_model (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.ack_hold    (ack_hold),
		.ack_delay   (ack_delay),
		.tx_req      (tx_req),
		.tx_resp_ack (tx_resp_ack),
		.rx_ack      (rx_ack),
		.tx_ack      (tx_ack),
		.tx_succ     (tx_succ),
		.tx_fail     (tx_fail),
		.rx_data     (rx_data),
		.rx_req      (rx_req),
		.rx_pend     (rx_pend)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #2 HCLK = ~HCLK;
	end

	always @(posedge HCLK)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout: test still running after %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic node_addr_t pick_addr();
		logic [31:0] r;
		r = xorshift();
		// few distinct nodes so same-address runs show up
		if (r[0])
			return node_addr_t'(r[9:8]);
		else
			return node_addr_t'(r[15:8]);
	endfunction

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		assert (got === exp)
		else
		begin
			fail_count++;
			$display("ERR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic require(input logic cond, input string what);
		assert (cond)
		else
		begin
			fail_count++;
			$display("at %0t ns: %s", $time, what);
			$display("Simulation finished: FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	// drives the address phase and returns one step into the data phase
	task automatic start_transfer(input logic wr, input logic [2:0] size,
		input logic [31:0] haddr);
		@(posedge HCLK);
		#1;
		HSEL = 1'b1;
		HTRANS = 2'b10;
		HWRITE = wr;
		HSIZE = size;
		HADDR = haddr;
		@(posedge HCLK);
		#1;
		HSEL = 1'b0;
		HTRANS = 2'b00;
	endtask

	task automatic finish_transfer();
		int low;
		low = 1;
		while (!HREADYOUT)
		begin
			low++;
			@(posedge HCLK);
			#1;
		end
		expect_eq(low, 4, "wait cycles of an accepted transfer");
		expect_eq(HRESP, 2'b00, "HRESP");
	endtask

	task automatic write_word(input node_addr_t a, input msg_data_t d);
		logic [31:0] r;
		r = xorshift();
		start_transfer(1'b1, 3'b010, {r[31:12], a, r[3:2], 2'b00});
		HWDATA = d;
		expect_eq(HREADYOUT, 1'b0, "HREADYOUT in the capture cycle");
		// push lands on this edge unless the queue is full
		@(posedge HCLK);
		if (exp_addr.size() < TX_SLOTS)
		begin
			exp_addr.push_back(a);
			exp_data.push_back(d);
		end
		#1;
		finish_transfer();
	endtask

	task automatic read_word();
		logic [31:0] r;
		msg_data_t expected;
		r = xorshift();
		start_transfer(1'b0, 3'b010, {r[31:2], 2'b00});
		expect_eq(HREADYOUT, 1'b0, "HREADYOUT in the capture cycle");
		@(posedge HCLK);
		if (exp_rx.size() != 0)
			last_popped = exp_rx.pop_front();
		expected = last_popped;
		#1;
		finish_transfer();
		expect_eq(HRDATA, expected, "HRDATA");
	endtask

	task automatic send_narrow(input logic wr, input logic [2:0] size);
		logic [31:0] r;
		r = xorshift();
		start_transfer(wr, size, r);
		HWDATA = xorshift();
		expect_eq(HREADYOUT, 1'b1, "HREADYOUT after a narrow transfer");
		repeat (3)
		begin
			@(posedge HCLK);
			#1;
			expect_eq(HREADYOUT, 1'b1, "HREADYOUT after a narrow transfer");
		end
	endtask

	task automatic offer_word(input msg_data_t d, input logic p);
		exp_rx.push_back(d);
		if (!p)
			frames_expected++;
		u_node_model.present_word(d, p);
		u_node_model.finish_word();
	endtask

	task automatic drain_tx();
		while ((exp_addr.size() != 0) || tx_req || tx_ack)
			@(negedge HCLK);
		repeat (2) @(posedge HCLK);
		#1;
	endtask

	// delivery and frame monitor sampled mid-cycle
	always @(negedge HCLK)
	begin
		if (!HRESETn)
		begin
			tx_req_prev = 1'b0;
			frame_prev = 1'b0;
		end
		else
		begin
			if (tx_req && !tx_req_prev)
			begin
				require(exp_addr.size() != 0,
					"node was offered a message that was never written");
				if (exp_addr.size() >= 2)
					pend_exp = (exp_addr[1] == exp_addr[0]);
				else
					pend_exp = 1'b0;
				expect_eq(tx_addr, exp_addr[0], "tx_addr");
				expect_eq(tx_data, exp_data[0], "tx_data");
				expect_eq(tx_pend, pend_exp, "tx_pend");
			end
			if (!tx_req && tx_req_prev)
			begin
				if (skip_pop)
					skip_pop = 1'b0;
				else if (exp_addr.size() != 0)
				begin
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
					delivered++;
				end
			end
			if (rx_frame_complete)
			begin
				require(!frame_prev,
					"rx_frame_complete stayed high for more than one cycle");
				frame_count++;
			end
			tx_req_prev = tx_req;
			frame_prev = rx_frame_complete;
		end
	end

	initial
	begin
		int i;
		int j;
		int n;
		int rise_n;
		int fall_n;
		logic [31:0] r;
		node_addr_t a;
		msg_data_t d;

		rng = 32'h1006_2945;
		fail_count = 0;
		delivered = 0;
		frame_count = 0;
		frames_expected = 0;
		last_popped = '0;
		skip_pop = 1'b0;
		HSEL = 1'b0;
		HWRITE = 1'b0;
		HREADY = 1'b1;
		HTRANS = 2'b00;
		HSIZE = 3'b010;
		HADDR = '0;
		HWDATA = '0;
		ack_hold = 1'b0;
		ack_delay = 2'd0;
		HRESETn = 1'b0;
		repeat (3) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		@(negedge HCLK);
		expect_eq(HREADYOUT, 1'b1, "HREADYOUT after reset");
		expect_eq(HRDATA, '0, "HRDATA after reset");
		expect_eq(HRESP, 2'b00, "HRESP after reset");
		expect_eq(tx_req, 1'b0, "tx_req after reset");
		expect_eq(tx_resp_ack, 1'b0, "tx_resp_ack after reset");
		expect_eq(rx_ack, 1'b0, "rx_ack after reset");
		expect_eq(rx_frame_complete, 1'b0, "rx_frame_complete after reset");
		expect_eq(rx_fifo_empty, 1'b1, "rx_fifo_empty after reset");

		// random write bursts with acks sometimes held back
		for (i = 0; i < 8; i++)
		begin
			r = xorshift();
			ack_delay = r[1:0];
			ack_hold = r[8];
			n = 1 + (r[7:4] % 5);
			for (j = 0; j < n; j++)
			begin
				a = pick_addr();
				d = xorshift();
				write_word(a, d);
			end
			ack_hold = 1'b0;
			drain_tx();
		end

		// overflow while the node stalls
		ack_hold = 1'b1;
		n = delivered;
		for (i = 0; i < 9; i++)
		begin
			a = pick_addr();
			d = xorshift();
			write_word(a, d);
		end
		expect_eq(exp_addr.size(), TX_SLOTS, "queued message count");
		ack_hold = 1'b0;
		drain_tx();
		expect_eq(delivered - n, TX_SLOTS, "messages delivered after overflow");

		// node responses where a failure flushes the queue
		for (i = 0; i < 4; i++)
		begin
			ack_hold = 1'b1;
			for (j = 0; j < 3; j++)
			begin
				a = pick_addr();
				d = xorshift();
				write_word(a, d);
			end
			r = xorshift();
			u_node_model.send_response(r[0] | (i == 0), rise_n, fall_n);
			expect_eq(rise_n, 1, "cycles until tx_resp_ack rises");
			expect_eq(fall_n, 1, "cycles until tx_resp_ack falls");
			if (r[0] | (i == 0))
			begin
				exp_addr.delete();
				exp_data.delete();
				skip_pop = tx_req;
			end
			ack_hold = 1'b0;
			drain_tx();
		end

		// receive path
		read_word();
		for (i = 0; i < 5; i++)
		begin
			r = xorshift();
			offer_word(xorshift(), r[0]);
		end
		for (i = 0; i < 5; i++)
			read_word();
		for (i = 0; i < `LC_FIFO_DEPTH; i++)
		begin
			r = xorshift();
			offer_word(xorshift(), r[0]);
		end
		expect_eq(rx_fifo_empty, 1'b0, "rx_fifo_empty with a full FIFO");
		d = xorshift();
		r = xorshift();
		exp_rx.push_back(d);
		if (!r[0])
			frames_expected++;
		u_node_model.present_word(d, r[0]);
		repeat (6)
		begin
			@(negedge HCLK);
			expect_eq(rx_ack, 1'b0, "rx_ack while the FIFO is full");
		end
		read_word();
		u_node_model.finish_word();
		for (i = 0; i < `LC_FIFO_DEPTH; i++)
			read_word();
		expect_eq(rx_fifo_empty, 1'b1, "rx_fifo_empty after reading all");
		read_word();
		repeat (3) @(posedge HCLK);
		expect_eq(frame_count, frames_expected, "rx_frame_complete pulses");

		// narrow transfers leave both queues alone
		send_narrow(1'b1, 3'b000);
		send_narrow(1'b1, 3'b001);
		drain_tx();
		r = xorshift();
		offer_word(xorshift(), r[0]);
		send_narrow(1'b0, 3'b000);
		send_narrow(1'b0, 3'b001);
		expect_eq(rx_fifo_empty, 1'b0, "rx_fifo_empty after narrow reads");
		read_word();
		expect_eq(rx_fifo_empty, 1'b1, "rx_fifo_empty after the last read");
		a = pick_addr();
		d = xorshift();
		write_word(a, d);
		drain_tx();
		expect_eq(frame_count, frames_expected, "rx_frame_complete pulses at the end");

		if (fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: bench/node_model.sv
`timescale 1ns/100ps

module node_model
	import layer_ctrl_pkg::*;
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       ack_hold,
	input  logic [1:0] ack_delay,
	input  logic       tx_req,
	input  logic       tx_resp_ack,
	input  logic       rx_ack,
	output logic       tx_ack,
	output logic       tx_succ,
	output logic       tx_fail,
	output msg_data_t  rx_data,
	output logic       rx_req,
	output logic       rx_pend
);

	int ack_wait;

	initial
	begin
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		rx_data = '0;
		rx_req = 1'b0;
		rx_pend = 1'b0;
		ack_wait = 0;
	end

	// ack each message after a short delay unless held off
	always @(posedge HCLK)
	begin
		#1;
		if (!HRESETn)
		begin
			tx_ack = 1'b0;
			ack_wait = 0;
		end
		else if (tx_ack)
		begin
			if (!tx_req)
				tx_ack = 1'b0;
		end
		else if (tx_req && !ack_hold)
		begin
			if (ack_wait >= ack_delay)
			begin
				tx_ack = 1'b1;
				ack_wait = 0;
			end
			else
				ack_wait++;
		end
		else
			ack_wait = 0;
	end

	task automatic present_word(input msg_data_t d, input logic p);
		@(posedge HCLK);
		#1;
		rx_data = d;
		rx_pend = p;
		rx_req = 1'b1;
	endtask

	// rest of the four-phase receive handshake
	task automatic finish_word();
		while (!rx_ack)
		begin
			@(posedge HCLK);
			#1;
		end
		rx_req = 1'b0;
		while (rx_ack)
		begin
			@(posedge HCLK);
			#1;
		end
	endtask

	// holds succ or fail until acknowledged, reports cycles to each edge
	task automatic send_response(input logic fail, output int rise_cycles,
		output int fall_cycles);
		@(posedge HCLK);
		#1;
		tx_fail = fail;
		tx_succ = !fail;
		rise_cycles = 0;
		while (!tx_resp_ack)
		begin
			@(posedge HCLK);
			#1;
			rise_cycles++;
		end
		tx_fail = 1'b0;
		tx_succ = 1'b0;
		fall_cycles = 0;
		while (tx_resp_ack)
		begin
			@(posedge HCLK);
			#1;
			fall_cycles++;
		end
	endtask

endmodule

// File: verilog/layer_ctrl_top.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module layer_ctrl_top
	import layer_ctrl_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic        HWRITE,
	input  logic        HREADY,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HADDR,
	input  msg_data_t   HWDATA,
	output logic        HREADYOUT,
	output logic [1:0]  HRESP,
	output msg_data_t   HRDATA,
	output node_addr_t  tx_addr,
	output msg_data_t   tx_data,
	output logic        tx_req,
	output logic        tx_pend,
	input  logic        tx_ack,
	input  logic        tx_succ,
	input  logic        tx_fail,
	output logic        tx_resp_ack,
	input  msg_data_t   rx_data,
	input  logic        rx_req,
	input  logic        rx_pend,
	output logic        rx_ack,
	output logic        rx_frame_complete,
	output logic        rx_fifo_empty
);

	logic       timer_load;
	logic       timer_done;
	logic       push;
	node_addr_t push_addr;
	msg_data_t  push_data;
	logic       tx_full;
	logic       tx_empty;
	logic       tx_pop;
	logic       rx_pop;
	logic       rx_push;
	logic       rx_full;
	msg_data_t  rx_word;

	// always OKAY
	assign HRESP = 2'b00;

	access_timer u_access_timer (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.load    (timer_load),
		.done    (timer_done)
	);

	ahb_access_fsm u_ahb_access_fsm (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.HSEL       (HSEL),
		.HWRITE     (HWRITE),
		.HREADY     (HREADY),
		.HTRANS     (HTRANS),
		.HSIZE      (HSIZE),
		.HADDR      (HADDR),
		.HWDATA     (HWDATA),
		.HREADYOUT  (HREADYOUT),
		.HRDATA     (HRDATA),
		.timer_load (timer_load),
		.timer_done (timer_done),
		.push       (push),
		.push_addr  (push_addr),
		.push_data  (push_data),
		.tx_full    (tx_full),
		.pop        (rx_pop),
		.rx_empty   (rx_fifo_empty),
		.rx_word    (rx_word)
	);

	// a failure report flushes everything queued
	tx_queue u_tx_queue (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.push      (push),
		.push_addr (push_addr),
		.push_data (push_data),
		.pop       (tx_pop),
		.flush     (tx_fail),
		.full      (tx_full),
		.empty     (tx_empty),
		.head_addr (tx_addr),
		.head_data (tx_data),
		.pend      (tx_pend)
	);

	rx_fifo u_rx_fifo (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.push    (rx_push),
		.wdata   (rx_data),
		.pop     (rx_pop),
		.rdata   (rx_word),
		.full    (rx_full),
		.empty   (rx_fifo_empty)
	);

	link_handshake u_link_handshake (
		.HCLK              (HCLK),
		.HRESETn           (HRESETn),
		.tx_empty          (tx_empty),
		.tx_pop            (tx_pop),
		.tx_req            (tx_req),
		.tx_ack            (tx_ack),
		.tx_succ           (tx_succ),
		.tx_fail           (tx_fail),
		.tx_resp_ack       (tx_resp_ack),
		.rx_req            (rx_req),
		.rx_pend           (rx_pend),
		.rx_ack            (rx_ack),
		.rx_full           (rx_full),
		.rx_push           (rx_push),
		.rx_frame_complete (rx_frame_complete)
	);

endmodule

// File: verilog/link_handshake.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module link_handshake
	import layer_ctrl_pkg::*;
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic tx_empty,
	output logic tx_pop,
	output logic tx_req,
	input  logic tx_ack,
	input  logic tx_succ,
	input  logic tx_fail,
	output logic tx_resp_ack,
	input  logic rx_req,
	input  logic rx_pend,
	output logic rx_ack,
	input  logic rx_full,
	output logic rx_push,
	output logic rx_frame_complete
);

	tx_link_state_t tx_state;
	rx_link_state_t rx_state;
	logic           tx_ack_q;
	logic           rx_pend_q;
	logic           rx_take;

	// transmit side
	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			tx_state    <= TX_IDLE;
			tx_req      <= 1'b0;
			tx_ack_q    <= 1'b0;
			tx_resp_ack <= 1'b0;
		end
		else
		begin
			tx_ack_q    <= tx_ack;
			// follows the node response level
			tx_resp_ack <= tx_succ || tx_fail;
			case (tx_state)
				TX_IDLE:
				begin
					if (!tx_empty && !tx_ack_q)
					begin
						tx_req   <= 1'b1;
						tx_state <= TX_WAIT;
					end
				end
				TX_WAIT:
				begin
					if (tx_ack_q)
					begin
						tx_req   <= 1'b0;
						tx_state <= TX_IDLE;
					end
				end
				default:
					tx_state <= TX_IDLE;
			endcase
		end
	end

	assign tx_pop = (tx_state == TX_WAIT) && tx_ack_q;

	// receive side, a full fifo holds off the ack
	assign rx_take = (rx_state == RX_IDLE) && rx_req && !rx_ack && !rx_full;
	assign rx_push = rx_take;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			rx_state          <= RX_IDLE;
			rx_ack            <= 1'b0;
			rx_pend_q         <= 1'b0;
			rx_frame_complete <= 1'b0;
		end
		else
		begin
			rx_frame_complete <= 1'b0;
			if (rx_take)
			begin
				rx_ack    <= 1'b1;
				rx_pend_q <= rx_pend;
				rx_state  <= RX_WAIT;
			end
			else if ((rx_state == RX_WAIT) && !rx_req)
			begin
				rx_ack            <= 1'b0;
				rx_state          <= RX_IDLE;
				rx_frame_complete <= !rx_pend_q;
			end
		end
	end

endmodule

// File: verilog/rx_fifo.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module rx_fifo
	import layer_ctrl_pkg::*;
(
	input  logic      HCLK,
	input  logic      HRESETn,
	input  logic      push,
	input  msg_data_t wdata,
	input  logic      pop,
	output msg_data_t rdata,
	output logic      full,
	output logic      empty
);

	localparam logic [`LC_PTR_W:0] DEPTH = `LC_FIFO_DEPTH;

	msg_data_t          mem [`LC_FIFO_DEPTH];
	fifo_ptr_t          wptr;
	fifo_ptr_t          rptr;
	logic [`LC_PTR_W:0] count;
	logic               do_push;
	logic               do_pop;

	assign full    = (count == DEPTH);
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
			rdata <= '0;
		end
		else
		begin
			if (do_push)
				wptr <= wptr + 1'b1;
			if (do_pop)
			begin
				rptr  <= rptr + 1'b1;
				rdata <= mem[rptr];
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (do_push)
			mem[wptr] <= wdata;
	end

endmodule

// File: verilog/tx_queue.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module tx_queue
	import layer_ctrl_pkg::*;
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       push,
	input  node_addr_t push_addr,
	input  msg_data_t  push_data,
	input  logic       pop,
	input  logic       flush,
	output logic       full,
	output logic       empty,
	output node_addr_t head_addr,
	output msg_data_t  head_data,
	output logic       pend
);

	node_addr_t addr_mem [`LC_FIFO_DEPTH];
	msg_data_t  data_mem [`LC_FIFO_DEPTH];
	fifo_ptr_t  wptr;
	fifo_ptr_t  rptr;
	fifo_ptr_t  wptr_next;
	fifo_ptr_t  rptr_next;
	logic       do_push;
	logic       do_pop;

	assign wptr_next = wptr + 1'b1;
	assign rptr_next = rptr + 1'b1;

	// one slot kept free so full and empty differ
	assign empty = (wptr == rptr);
	assign full  = (wptr_next == rptr);

	assign do_push = push && !full && !flush;
	assign do_pop  = pop && !empty && !flush;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			wptr <= '0;
			rptr <= '0;
		end
		else if (flush)
		begin
			wptr <= '0;
			rptr <= '0;
		end
		else
		begin
			if (do_push)
				wptr <= wptr_next;
			if (do_pop)
				rptr <= rptr_next;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (do_push)
		begin
			addr_mem[wptr] <= push_addr;
			data_mem[wptr] <= push_data;
		end
	end

	assign head_addr = addr_mem[rptr];
	assign head_data = data_mem[rptr];

	// second oldest entry goes to the same node
	assign pend = !empty && (rptr_next != wptr) && (addr_mem[rptr_next] == addr_mem[rptr]);

endmodule

// File: verilog/ahb_access_fsm.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module ahb_access_fsm
	import layer_ctrl_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic        HWRITE,
	input  logic        HREADY,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HADDR,
	input  msg_data_t   HWDATA,
	output logic        HREADYOUT,
	output msg_data_t   HRDATA,
	output logic        timer_load,
	input  logic        timer_done,
	output logic        push,
	output node_addr_t  push_addr,
	output msg_data_t   push_data,
	input  logic        tx_full,
	output logic        pop,
	input  logic        rx_empty,
	input  msg_data_t   rx_word
);

	access_state_t state;
	logic          write_q;
	node_addr_t    addr_q;
	logic          accept;

	// word transfers only, nonseq or seq
	assign accept = HSEL && HREADY && HTRANS[1] && (HSIZE == 3'b010);

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			state   <= IDLE;
			write_q <= 1'b0;
			HRDATA  <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (accept)
					begin
						state   <= CAPTURE;
						write_q <= HWRITE;
					end
				end
				CAPTURE:
					state <= SETTLE;
				SETTLE:
				begin
					if (timer_done)
						state <= RESPOND;
				end
				RESPOND:
				begin
					HRDATA <= rx_word;
					state  <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if ((state == IDLE) && accept)
			addr_q <= HADDR[11:4];
	end

	assign HREADYOUT = (state == IDLE);
	assign timer_load = (state == CAPTURE);

	// data phase strobes, dropped silently on full or empty
	assign push      = (state == CAPTURE) && write_q && !tx_full;
	assign pop       = (state == CAPTURE) && !write_q && !rx_empty;
	assign push_addr = addr_q;
	assign push_data = HWDATA;

endmodule

// File: verilog/access_timer.sv
`timescale 1ns/100ps
`include "layer_ctrl_consts.svh"

module access_timer
	import layer_ctrl_pkg::*;
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic load,
	output logic done
);

	settle_cnt_t count;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			count <= '0;
		end
		else if (load)
		begin
			count <= settle_cnt_t'(`LC_SETTLE_CYCLES);
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	// last settle cycle, count hits zero at the next edge
	assign done = (count == settle_cnt_t'(1));

endmodule

// File: verilog/layer_ctrl_pkg.sv
`include "layer_ctrl_consts.svh"

package layer_ctrl_pkg;

	typedef logic [`LC_ADDR_W-1:0] node_addr_t;
	typedef logic [`LC_DATA_W-1:0] msg_data_t;
	typedef logic [`LC_PTR_W-1:0] fifo_ptr_t;
	typedef logic [1:0] settle_cnt_t;

	// ahb data phase sequencing
	typedef enum logic [1:0] {
		IDLE,
		CAPTURE,
		SETTLE,
		RESPOND
	} access_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_WAIT
	} tx_link_state_t;

	typedef enum logic {
		RX_IDLE,
		RX_WAIT
	} rx_link_state_t;

endpackage

// File: verilog/layer_ctrl_consts.svh
`ifndef LAYER_CTRL_CONSTS_SVH
`define LAYER_CTRL_CONSTS_SVH

// node address and message word widths
`define LC_ADDR_W 8
`define LC_DATA_W 32

// fifo geometry
`define LC_FIFO_DEPTH 8
`define LC_PTR_W 3

// wait cycles between capture and respond
`define LC_SETTLE_CYCLES 2

`endif
